/* verilog.f */
+incdir+tb
hdl/bus_pkg.sv
hdl/htif_pkg.sv
hdl/host_fifo.sv
hdl/htif_write_channel.sv
hdl/htif_read_channel.sv
hdl/htif_bridge.sv
tb/tb_htif_bridge.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_htif_bridge \
    -o sim_htif_bridge \
  && ./obj_dir/sim_htif_bridge | tee /dev/stderr | grep -q "^Result: PASSED$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb/tb_bus_tasks.svh */
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
    errs++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s: %s", test_name, msg);
    errs++;
  endtask

  // drive aw and w together, drop them once the DUT has taken them
  task automatic write_request(input logic [31:0] addr, input logic [BUS_ID_W-1:0] id,
                               input host_word_t data);
    aw.addr  = addr;
    aw.id    = id;
    w.data   = data;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    while (!(aw_ready && w_ready))
      @(negedge host_clk);
    // transfer on the edge in between
    @(negedge host_clk);
    aw_valid = 1'b0;
    w_valid  = 1'b0;
  endtask

  task automatic wait_write_ack(input logic [BUS_ID_W-1:0] id);
    b_ready = 1'b1;
    while (!b_valid)
      @(negedge host_clk);
    if (b.id !== id)
      report_mismatch("b.id", 32'(id), 32'(b.id));
    @(negedge host_clk);
    b_ready = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [BUS_ID_W-1:0] id,
                           input host_word_t data);
    write_request(addr, id, data);
    wait_write_ack(id);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [BUS_ID_W-1:0] id,
                          output logic [31:0] data);
    ar.addr  = addr;
    ar.id    = id;
    ar_valid = 1'b1;
    while (!ar_ready)
      @(negedge host_clk);
    @(negedge host_clk);
    ar_valid = 1'b0;
    r_ready  = 1'b1;
    while (!r_valid)
      @(negedge host_clk);
    if (r.id !== id)
      report_mismatch("r.id", 32'(id), 32'(r.id));
    if (r.last !== 1'b1)
      report_mismatch("r.last", 32'd1, 32'(r.last));
    data = r.data;
    @(negedge host_clk);
    r_ready = 1'b0;
  endtask

`endif

/* tb/tb_htif_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_htif_bridge;

  import bus_pkg::*;
  import htif_pkg::*;

  // roughly 400 transactions of up to 40 cycles each plus margin
  localparam int CYCLE_LIMIT = 20000;

  logic host_clk;
  logic reset;
  bus_aw_t aw;
  bus_w_t w;
  bus_b_t b;
  bus_ar_t ar;
  bus_r_t r;
  logic aw_valid;
  logic aw_ready;
  logic w_valid;
  logic w_ready;
  logic b_valid;
  logic b_ready;
  logic ar_valid;
  logic ar_ready;
  logic r_valid;
  logic r_ready;
  host_word_t host_in_bits;
  host_word_t host_out_bits;
  logic host_in_valid;
  logic host_out_valid;
  logic host_out_ready;
  logic reset_cpu;
  logic host_in_ready = 1'b0;

  integer seed = 32'ha45d;
  int cycles = 0;
  int errs = 0;
  int tests_done = 0;
  int test_start_errs = 0;
  string test_name = "setup";
  // mode 0 holds host_in_ready low, 1 holds it high, 2 plays ready_bits
  int in_ready_mode = 0;
  logic [127:0] ready_bits;
  int rst_pulses = 0;
  int rst_bad = 0;
  int in_checked = 0;
  int pulses_before;
  int round;
  int n;
  logic [31:0] rd_data;
  logic [BUS_ID_W-1:0] id;
  host_word_t word;
  // model queues of written words and of words the chip took
  host_word_t in_q[$];
  host_word_t taken_q[$];
  host_word_t out_q[$];

  `include "tb_bus_tasks.svh"

  htif_bridge dut0 (
    .host_clk (host_clk), .reset (reset),
    .aw (aw), .aw_valid (aw_valid), .aw_ready (aw_ready),
    .w (w), .w_valid (w_valid), .w_ready (w_ready),
    .b (b), .b_valid (b_valid), .b_ready (b_ready),
    .ar (ar), .ar_valid (ar_valid), .ar_ready (ar_ready),
    .r (r), .r_valid (r_valid), .r_ready (r_ready),
    .host_in_bits (host_in_bits), .host_in_valid (host_in_valid),
    .host_in_ready (host_in_ready),
    .host_out_bits (host_out_bits), .host_out_valid (host_out_valid),
    .host_out_ready (host_out_ready),
    .reset_cpu (reset_cpu)
  );

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic rand_bit();
    logic [31:0] v;
    v = $random(seed);
    return v[0];
  endfunction

  function automatic logic [BUS_ID_W-1:0] rand_id();
    logic [31:0] v;
    v = $random(seed);
    return v[BUS_ID_W-1:0];
  endfunction

  // random address bits around the register index
  function automatic logic [31:0] reg_addr(input reg_idx_t idx);
    logic [31:0] a;
    a = $random(seed);
    a[REG_IDX_LSB +: REG_IDX_W] = idx;
    return a;
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
    test_start_errs = errs;
  endtask

  task automatic finish_test();
    $display("test %s finished with %0d errors", test_name, errs - test_start_errs);
    tests_done++;
  endtask

  // chip must end up with exactly the written words in order
  task automatic check_stream();
    while (taken_q.size() < in_q.size())
      @(negedge host_clk);
    repeat (2) @(negedge host_clk);
    if (taken_q.size() != in_q.size())
      report_failure($sformatf("chip took %0d words but %0d were written",
                               taken_q.size(), in_q.size()));
    else
      for (int k = in_checked; k < in_q.size(); k++)
        if (taken_q[k] !== in_q[k])
          report_mismatch($sformatf("host_in word %0d", k), in_q[k], taken_q[k]);
    in_checked = in_q.size();
  endtask

  initial
  begin
    host_clk = 1'b0;
    forever #50 host_clk = ~host_clk;
  end

  always @(posedge host_clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  // chip side of host_in and the reset_cpu watch
  always @(negedge host_clk)
  begin
    if (in_ready_mode == 2)
      host_in_ready = ready_bits[7'(cycles)];
    else
      host_in_ready = (in_ready_mode == 1);
    if (host_in_valid && host_in_ready)
      taken_q.push_back(host_in_bits);
    if (reset_cpu)
    begin
      rst_pulses++;
      if (!aw_ready)
        rst_bad++;
    end
  end

  initial
  begin
    aw = '0;
    w = '0;
    ar = '0;
    aw_valid = 1'b0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    host_out_bits = '0;
    host_out_valid = 1'b0;
    reset = 1'b1;
    ready_bits = {rand_word(), rand_word(), rand_word(), rand_word()};
    repeat (8) @(negedge host_clk);
    reset = 1'b0;
    @(negedge host_clk);

    begin_test("reset_state");
    // aw_ready w_ready b_valid r_valid reset_cpu host_in_valid ar_ready host_out_ready
    if ({aw_ready, w_ready, b_valid, r_valid, reset_cpu, host_in_valid, ar_ready,
         host_out_ready} !== 8'b0000_0011)
      report_mismatch("outputs", 32'h03, 32'({aw_ready, w_ready, b_valid, r_valid,
                      reset_cpu, host_in_valid, ar_ready, host_out_ready}));
    bus_read(reg_addr(REG_DCOUNT), rand_id(), rd_data);
    if (rd_data !== 32'd0)
      report_mismatch("count", 32'd0, rd_data);
    finish_test();

    begin_test("host_in_stream");
    in_ready_mode = 2;
    repeat (100)
    begin
      word = rand_word();
      in_q.push_back(word);
      bus_write(reg_addr(REG_WFIFO), rand_id(), word);
    end
    check_stream();
    finish_test();

    begin_test("host_in_backpressure");
    in_ready_mode = 0;
    @(negedge host_clk);
    repeat (32)
    begin
      word = rand_word();
      in_q.push_back(word);
      bus_write(reg_addr(REG_WFIFO), rand_id(), word);
    end
    word = rand_word();
    in_q.push_back(word);
    id = rand_id();
    write_request(reg_addr(REG_WFIFO), id, word);
    repeat (10)
    begin
      if (b_valid)
        report_failure("write acked while the host-in FIFO was full");
      @(negedge host_clk);
    end
    in_ready_mode = 1;
    wait_write_ack(id);
    check_stream();
    finish_test();

    begin_test("host_out_stream");
    round = 0;
    while (out_q.size() < 32 && round < 20)
    begin
      repeat (10)
      begin
        host_out_valid = rand_bit();
        host_out_bits = rand_word();
        if (host_out_valid && host_out_ready)
          out_q.push_back(host_out_bits);
        @(negedge host_clk);
      end
      host_out_valid = 1'b0;
      bus_read(reg_addr(REG_DCOUNT), rand_id(), rd_data);
      if (rd_data !== 32'(out_q.size()))
        report_mismatch("count", 32'(out_q.size()), rd_data);
      round++;
    end
    // a full FIFO refuses further words
    host_out_valid = 1'b1;
    host_out_bits = rand_word();
    if (host_out_ready)
      report_failure("host_out_ready high with 32 words held");
    @(negedge host_clk);
    host_out_valid = 1'b0;
    bus_read(reg_addr(REG_DCOUNT), rand_id(), rd_data);
    if (rd_data !== 32'd32)
      report_mismatch("full count", 32'd32, rd_data);
    n = out_q.size();
    repeat (n)
    begin
      bus_read(reg_addr(REG_RFIFO), rand_id(), rd_data);
      word = out_q.pop_front();
      if (rd_data !== word)
        report_mismatch("host_out word", word, rd_data);
    end
    bus_read(reg_addr(REG_DCOUNT), rand_id(), rd_data);
    if (rd_data !== 32'd0)
      report_mismatch("drained count", 32'd0, rd_data);
    finish_test();

    begin_test("reset_register");
    pulses_before = rst_pulses;
    bus_write(reg_addr(REG_RESET), rand_id(), rand_word());
    if (rst_pulses - pulses_before != 1)
      report_mismatch("reset_cpu cycles", 32'd1, 32'(rst_pulses - pulses_before));
    if (rst_bad != 0)
      report_failure("reset_cpu was high while aw_ready was low");
    bus_write(reg_addr(5'd9), rand_id(), rand_word());
    if (rst_pulses - pulses_before != 1)
      report_failure("write to an unmapped index pulsed reset_cpu");
    check_stream();
    finish_test();

    begin_test("id_echo");
    repeat (20)
    begin
      bus_write(reg_addr(5'd17), rand_id(), rand_word());
      bus_read(reg_addr(REG_DCOUNT), rand_id(), rd_data);
      if (rd_data !== 32'd0)
        report_mismatch("count", 32'd0, rd_data);
    end
    finish_test();

    $display("%0d tests run, %0d errors", tests_done, errs);
    if (errs == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/htif_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module htif_bridge (
  input  logic                 host_clk,
  input  logic                 reset,
  input  bus_pkg::bus_aw_t     aw,
  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  bus_pkg::bus_w_t      w,
  input  logic                 w_valid,
  output logic                 w_ready,
  output bus_pkg::bus_b_t      b,
  output logic                 b_valid,
  input  logic                 b_ready,
  input  bus_pkg::bus_ar_t     ar,
  input  logic                 ar_valid,
  output logic                 ar_ready,
  output bus_pkg::bus_r_t      r,
  output logic                 r_valid,
  input  logic                 r_ready,
  output htif_pkg::host_word_t host_in_bits,
  output logic                 host_in_valid,
  input  logic                 host_in_ready,
  input  htif_pkg::host_word_t host_out_bits,
  input  logic                 host_out_valid,
  output logic                 host_out_ready,
  output logic                 reset_cpu
);

  import htif_pkg::*;

  // host to chip path
  logic        in_push;
  logic        in_pop;
  host_word_t  in_data;
  logic        in_empty;
  logic        in_full;

  // chip to host path
  logic        out_push;
  logic        out_pop;
  host_word_t  out_head;
  logic        out_empty;
  logic        out_full;
  fifo_count_t out_count;

  htif_write_channel u_write (
    .host_clk  (host_clk),
    .reset     (reset),
    .aw        (aw),
    .aw_valid  (aw_valid),
    .aw_ready  (aw_ready),
    .w         (w),
    .w_valid   (w_valid),
    .w_ready   (w_ready),
    .b         (b),
    .b_valid   (b_valid),
    .b_ready   (b_ready),
    .fifo_full (in_full),
    .push      (in_push),
    .push_data (in_data),
    .reset_cpu (reset_cpu)
  );

  htif_read_channel u_read (
    .host_clk   (host_clk),
    .reset      (reset),
    .ar         (ar),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .fifo_head  (out_head),
    .fifo_count (out_count),
    .fifo_empty (out_empty),
    .pop        (out_pop)
  );

  // chip side handshakes
  assign host_in_valid  = !in_empty;
  assign in_pop         = host_in_valid && host_in_ready;
  assign host_out_ready = !out_full;
  assign out_push       = host_out_valid && host_out_ready;

  host_fifo host_in_fifo (
    .host_clk (host_clk),
    .reset    (reset),
    .push     (in_push),
    .pop      (in_pop),
    .din      (in_data),
    .dout     (host_in_bits),
    .empty    (in_empty),
    .full     (in_full),
    .count    ()
  );

  host_fifo host_out_fifo (
    .host_clk (host_clk),
    .reset    (reset),
    .push     (out_push),
    .pop      (out_pop),
    .din      (host_out_bits),
    .dout     (out_head),
    .empty    (out_empty),
    .full     (out_full),
    .count    (out_count)
  );

endmodule

`default_nettype wire

/* hdl/htif_read_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module htif_read_channel (
  input  logic                  host_clk,
  input  logic                  reset,
  input  bus_pkg::bus_ar_t      ar,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  output bus_pkg::bus_r_t       r,
  output logic                  r_valid,
  input  logic                  r_ready,
  input  htif_pkg::host_word_t  fifo_head,
  input  htif_pkg::fifo_count_t fifo_count,
  input  logic                  fifo_empty,
  output logic                  pop
);

  import bus_pkg::*;
  import htif_pkg::*;

  typedef enum logic {
    st_idle,
    st_read
  } rd_state_t;

  rd_state_t           state;
  reg_idx_t            idx_q;
  logic [BUS_ID_W-1:0] id_q;

  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      state <= st_idle;
      idx_q <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (ar_valid)
          begin
            state <= st_read;
            idx_q <= ar.addr[REG_IDX_LSB +: REG_IDX_W];
          end
        end
        default:
        begin
          if (r_ready)
          begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge host_clk)
  begin
    if ((state == st_idle) && ar_valid)
    begin
      id_q <= ar.id;
    end
  end

  assign ar_ready = (state == st_idle);
  assign r_valid  = (state == st_read);
  assign r.last   = r_valid;
  assign r.id     = id_q;

  // count is zero-extended; any other index returns the fifo head
  assign r.data = (idx_q == REG_DCOUNT) ?
                  {{(BUS_DATA_W - FIFO_COUNT_W){1'b0}}, fifo_count} : fifo_head;

  // consume the head only once the host has taken it
  assign pop = r_valid && r_ready && (idx_q == REG_RFIFO) && !fifo_empty;

  // response is held until accepted
  a_r_hold: assert property (
    @(posedge host_clk) disable iff (reset)
    r_valid && !r_ready |=> r_valid
  );

endmodule

`default_nettype wire

/* hdl/htif_write_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module htif_write_channel (
  input  logic                 host_clk,
  input  logic                 reset,
  input  bus_pkg::bus_aw_t     aw,
  input  logic                 aw_valid,
  output logic                 aw_ready,
  input  bus_pkg::bus_w_t      w,
  input  logic                 w_valid,
  output logic                 w_ready,
  output bus_pkg::bus_b_t      b,
  output logic                 b_valid,
  input  logic                 b_ready,
  input  logic                 fifo_full,
  output logic                 push,
  output htif_pkg::host_word_t push_data,
  output logic                 reset_cpu
);

  import bus_pkg::*;
  import htif_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_ack
  } wr_state_t;

  wr_state_t           state;
  reg_idx_t            idx_q;
  logic [BUS_ID_W-1:0] id_q;
  host_word_t          data_q;
  logic                in_write;
  logic                done;

  assign in_write = (state == st_write);
  // only a data write waits on a full host-in fifo
  assign done = in_write && ((idx_q != REG_WFIFO) || !fifo_full);

  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      state <= st_idle;
      idx_q <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (aw_valid && w_valid)
          begin
            state <= st_write;
            idx_q <= aw.addr[REG_IDX_LSB +: REG_IDX_W];
          end
        end
        st_write:
        begin
          if (done)
          begin
            state <= st_ack;
          end
        end
        st_ack:
        begin
          if (b_ready)
          begin
            state <= st_idle;
          end
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  // id and data captured with the request
  always_ff @(posedge host_clk)
  begin
    if ((state == st_idle) && aw_valid && w_valid)
    begin
      id_q   <= aw.id;
      data_q <= w.data;
    end
  end

  assign aw_ready = in_write;
  assign w_ready  = in_write;

  // unmapped indices just ack with no effect
  assign push      = in_write && (idx_q == REG_WFIFO) && !fifo_full;
  assign push_data = data_q;
  assign reset_cpu = in_write && (idx_q == REG_RESET);

  assign b_valid = (state == st_ack);
  assign b.id    = id_q;

  // chip reset is a single-cycle strobe
  a_reset_one_cycle: assert property (
    @(posedge host_clk) disable iff (reset)
    reset_cpu |=> !reset_cpu
  );

endmodule

`default_nettype wire

/* hdl/host_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module host_fifo (
  input  logic                  host_clk,
  input  logic                  reset,
  input  logic                  push,
  input  logic                  pop,
  input  htif_pkg::host_word_t  din,
  output htif_pkg::host_word_t  dout,
  output logic                  empty,
  output logic                  full,
  output htif_pkg::fifo_count_t count
);

  import htif_pkg::*;

  host_word_t            mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;

  // head word is always on the read port
  assign dout = mem[rd_ptr];

  // storage array
  always_ff @(posedge host_clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge host_clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      empty  <= 1'b1;
      full   <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
      end
      // push and pop together leave occupancy and flags alone
      if (push && !pop)
      begin
        count <= count + fifo_count_t'(1);
        empty <= 1'b0;
        full  <= (count == fifo_count_t'(FIFO_DEPTH - 1));
      end
      else if (pop && !push)
      begin
        count <= count - fifo_count_t'(1);
        full  <= 1'b0;
        empty <= (count == fifo_count_t'(1));
      end
    end
  end

  // writers must hold off while full
  a_no_push_full: assert property (
    @(posedge host_clk) disable iff (reset)
    full |-> !push
  );

  // readers must hold off while empty
  a_no_pop_empty: assert property (
    @(posedge host_clk) disable iff (reset)
    empty |-> !pop
  );

endmodule

`default_nettype wire

/* hdl/htif_pkg.sv */
`default_nettype none

package htif_pkg;

  // one word on the chip-side streams
  localparam int HOST_WORD_W = 32;
  typedef logic [HOST_WORD_W-1:0] host_word_t;

  // register index sits in addr[6:2]
  localparam int REG_IDX_LSB = 2;
  localparam int REG_IDX_W   = 5;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // write map
  localparam reg_idx_t REG_WFIFO = 5'd0;
  localparam reg_idx_t REG_RESET = 5'd31;

  // read map
  localparam reg_idx_t REG_DCOUNT = 5'd0;
  localparam reg_idx_t REG_RFIFO  = 5'd1;

  // fifo sizing
  // count is one bit wider than the pointers so a full fifo reads 32
  localparam int FIFO_DEPTH   = 32;
  localparam int FIFO_PTR_W   = 5;
  localparam int FIFO_COUNT_W = 6;
  typedef logic [FIFO_COUNT_W-1:0] fifo_count_t;

endpackage

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // host bus widths
  localparam int BUS_ADDR_W = 32;
  localparam int BUS_DATA_W = 32;
  localparam int BUS_ID_W   = 12;

  // write address channel
  typedef struct packed {
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_ID_W-1:0]   id;
  } bus_aw_t;

  // write data channel carries a single beat
  typedef struct packed {
    logic [BUS_DATA_W-1:0] data;
  } bus_w_t;

  // write response echoes the request id
  typedef struct packed {
    logic [BUS_ID_W-1:0] id;
  } bus_b_t;

  // read address channel
  typedef struct packed {
    logic [BUS_ADDR_W-1:0] addr;
    logic [BUS_ID_W-1:0]   id;
  } bus_ar_t;

  // read data channel
  // last is set on every beat since reads are single beat
  typedef struct packed {
    logic [BUS_DATA_W-1:0] data;
    logic [BUS_ID_W-1:0]   id;
    logic                  last;
  } bus_r_t;

endpackage

`default_nettype wire
